// ==== dbg_dmi_defines.svh ====
`ifndef DBG_DMI_DEFINES_SVH
`define DBG_DMI_DEFINES_SVH

// ******************************
// DMI widths
// ******************************

`define DMI_ABITS        7
`define DMI_DATA_W       32

// Status, data and address chained in the DMI data register
`define DMI_DR_W         (`DMI_ABITS + `DMI_DATA_W + 2)

// ******************************
// JTAG and DTMCS fields
// ******************************

`define JTAG_IR_W        5

// Version, idle hint and the dmireset bit of DTMCS
`define DTM_VERSION      4'd1
`define DTM_IDLE         3'd1
`define DTMCS_DMIRESET   16

// ******************************
// Core/uncore routing
// ******************************

// Inclusive address window of the uncore target
`define UNCORE_ADDR_LO   7'h20
`define UNCORE_ADDR_HI   7'h4F

// Flops per synchronizer chain
`define SYNC_STAGES      2

`endif

// ==== dbg_dmi_pkg.sv ====
`default_nettype none
`include "dbg_dmi_defines.svh"

package dbg_dmi_pkg;

   // One DMI request as it leaves the TAP
   typedef struct packed {
      logic                   wr_en;
      logic [`DMI_ABITS-1:0]  addr;
      logic [`DMI_DATA_W-1:0] wdata;
   } dmi_req_t;

   // IEEE 1149.1 TAP controller states
   typedef enum logic [3:0] {
      EXIT2_DR         = 4'h0,
      EXIT1_DR         = 4'h1,
      SHIFT_DR         = 4'h2,
      PAUSE_DR         = 4'h3,
      SELECT_IR        = 4'h4,
      UPDATE_DR        = 4'h5,
      CAPTURE_DR       = 4'h6,
      SELECT_DR        = 4'h7,
      EXIT2_IR         = 4'h8,
      EXIT1_IR         = 4'h9,
      SHIFT_IR         = 4'hA,
      PAUSE_IR         = 4'hB,
      RUN_TEST_IDLE    = 4'hC,
      UPDATE_IR        = 4'hD,
      CAPTURE_IR       = 4'hE,
      TEST_LOGIC_RESET = 4'hF
   } tap_state_e;

   typedef enum logic [`JTAG_IR_W-1:0] {
      IDCODE     = 5'h01,
      DTMCS      = 5'h10,
      DMI_ACCESS = 5'h11,
      BYPASS     = 5'h1F
   } jtag_instr_e;

   // Request ops going in, status codes coming out
   typedef enum logic [1:0] {
      NOP   = 2'd0,
      READ  = 2'd1,
      WRITE = 2'd2,
      BUSY  = 2'd3
   } dmi_op_e;

   // Status OK has the same encoding as NOP
   localparam dmi_op_e OK = NOP;

endpackage

`default_nettype wire

// ==== dbg_jtag_tap.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dbg_dmi_defines.svh"

module dbg_jtag_tap (
   input  wire logic                   jtag_tck,
   input  wire logic                   jtag_trst_n,
   input  wire logic                   jtag_tms,
   input  wire logic                   jtag_tdi,
   input  wire logic [31:1]            jtag_id,
   input  wire logic                   ack_toggle,
   input  wire logic [`DMI_DATA_W-1:0] rsp_data,
   output logic                        jtag_tdo,
   output logic                        jtag_tdo_en,
   output dbg_dmi_pkg::dmi_req_t       dmi_req,
   output logic                        req_toggle
);

   dbg_dmi_pkg::tap_state_e  state;
   dbg_dmi_pkg::tap_state_e  state_nxt;
   dbg_dmi_pkg::jtag_instr_e instr;
   dbg_dmi_pkg::dmi_op_e     dmi_op;
   dbg_dmi_pkg::dmi_op_e     dmi_status;
   logic [`JTAG_IR_W-1:0]    ir;
   logic [`JTAG_IR_W-1:0]    ir_shift;
   logic [`DMI_DR_W-1:0]     dr;
   logic [`DMI_DR_W-1:0]     capture_val;
   logic                     pending;
   logic                     busy;

   // Request in flight until the acknowledge toggle catches up
   assign pending    = req_toggle ^ ack_toggle;
   assign dmi_op     = dbg_dmi_pkg::dmi_op_e'(dr[1:0]);
   assign dmi_status = (busy || pending) ? dbg_dmi_pkg::BUSY : dbg_dmi_pkg::OK;

   // ******************************
   // TAP state machine
   // ******************************

   always_comb begin
      case (state)
         dbg_dmi_pkg::TEST_LOGIC_RESET:
            state_nxt = jtag_tms ? dbg_dmi_pkg::TEST_LOGIC_RESET : dbg_dmi_pkg::RUN_TEST_IDLE;
         dbg_dmi_pkg::RUN_TEST_IDLE:
            state_nxt = jtag_tms ? dbg_dmi_pkg::SELECT_DR : dbg_dmi_pkg::RUN_TEST_IDLE;
         dbg_dmi_pkg::SELECT_DR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::SELECT_IR : dbg_dmi_pkg::CAPTURE_DR;
         dbg_dmi_pkg::CAPTURE_DR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::EXIT1_DR : dbg_dmi_pkg::SHIFT_DR;
         dbg_dmi_pkg::SHIFT_DR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::EXIT1_DR : dbg_dmi_pkg::SHIFT_DR;
         dbg_dmi_pkg::EXIT1_DR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::UPDATE_DR : dbg_dmi_pkg::PAUSE_DR;
         dbg_dmi_pkg::PAUSE_DR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::EXIT2_DR : dbg_dmi_pkg::PAUSE_DR;
         dbg_dmi_pkg::EXIT2_DR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::UPDATE_DR : dbg_dmi_pkg::SHIFT_DR;
         dbg_dmi_pkg::UPDATE_DR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::SELECT_DR : dbg_dmi_pkg::RUN_TEST_IDLE;
         dbg_dmi_pkg::SELECT_IR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::TEST_LOGIC_RESET : dbg_dmi_pkg::CAPTURE_IR;
         dbg_dmi_pkg::CAPTURE_IR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::EXIT1_IR : dbg_dmi_pkg::SHIFT_IR;
         dbg_dmi_pkg::SHIFT_IR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::EXIT1_IR : dbg_dmi_pkg::SHIFT_IR;
         dbg_dmi_pkg::EXIT1_IR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::UPDATE_IR : dbg_dmi_pkg::PAUSE_IR;
         dbg_dmi_pkg::PAUSE_IR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::EXIT2_IR : dbg_dmi_pkg::PAUSE_IR;
         dbg_dmi_pkg::EXIT2_IR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::UPDATE_IR : dbg_dmi_pkg::SHIFT_IR;
         dbg_dmi_pkg::UPDATE_IR:
            state_nxt = jtag_tms ? dbg_dmi_pkg::SELECT_DR : dbg_dmi_pkg::RUN_TEST_IDLE;
         default:
            state_nxt = dbg_dmi_pkg::TEST_LOGIC_RESET;
      endcase
   end

   // State and instruction register
   always_ff @(posedge jtag_tck or negedge jtag_trst_n) begin
      if (!jtag_trst_n) begin
         state    <= dbg_dmi_pkg::TEST_LOGIC_RESET;
         ir       <= dbg_dmi_pkg::IDCODE;
         ir_shift <= '0;
      end else begin
         state <= state_nxt;
         case (state)
            dbg_dmi_pkg::TEST_LOGIC_RESET: ir       <= dbg_dmi_pkg::IDCODE;
            dbg_dmi_pkg::CAPTURE_IR:       ir_shift <= `JTAG_IR_W'(1);
            dbg_dmi_pkg::SHIFT_IR:         ir_shift <= {jtag_tdi, ir_shift[`JTAG_IR_W-1:1]};
            dbg_dmi_pkg::UPDATE_IR:        ir       <= ir_shift;
            default: ;
         endcase
      end
   end

   // Unknown codes fall back to BYPASS
   always_comb begin
      case (ir)
         dbg_dmi_pkg::IDCODE:     instr = dbg_dmi_pkg::IDCODE;
         dbg_dmi_pkg::DTMCS:      instr = dbg_dmi_pkg::DTMCS;
         dbg_dmi_pkg::DMI_ACCESS: instr = dbg_dmi_pkg::DMI_ACCESS;
         default:                 instr = dbg_dmi_pkg::BYPASS;
      endcase
   end

   // ******************************
   // Data registers
   // ******************************

   always_comb begin
      capture_val = '0;
      case (instr)
         dbg_dmi_pkg::IDCODE:
            capture_val[31:0] = {jtag_id, 1'b1};
         dbg_dmi_pkg::DTMCS:
            capture_val[31:0] = {17'd0, `DTM_IDLE, dmi_status, 6'(`DMI_ABITS), `DTM_VERSION};
         dbg_dmi_pkg::DMI_ACCESS:
            capture_val = {dmi_req.addr, rsp_data, dmi_status};
         default:
            capture_val = '0;
      endcase
   end

   // Shift length follows the selected register
   always_ff @(posedge jtag_tck) begin
      if (state == dbg_dmi_pkg::CAPTURE_DR) begin
         dr <= capture_val;
      end else if (state == dbg_dmi_pkg::SHIFT_DR) begin
         case (instr)
            dbg_dmi_pkg::IDCODE,
            dbg_dmi_pkg::DTMCS:      dr <= {{(`DMI_DR_W-32){1'b0}}, jtag_tdi, dr[31:1]};
            dbg_dmi_pkg::DMI_ACCESS: dr <= {jtag_tdi, dr[`DMI_DR_W-1:1]};
            default:                 dr <= {{(`DMI_DR_W-1){1'b0}}, jtag_tdi};
         endcase
      end
   end

   // Request launch and sticky busy
   always_ff @(posedge jtag_tck or negedge jtag_trst_n) begin
      if (!jtag_trst_n) begin
         req_toggle <= 1'b0;
         busy       <= 1'b0;
         dmi_req    <= '0;
      end else begin
         if (state == dbg_dmi_pkg::CAPTURE_DR && instr == dbg_dmi_pkg::DMI_ACCESS && pending) begin
            busy <= 1'b1;
         end
         if (state == dbg_dmi_pkg::UPDATE_DR) begin
            if (instr == dbg_dmi_pkg::DTMCS && dr[`DTMCS_DMIRESET]) begin
               busy <= 1'b0;
            end
            if (instr == dbg_dmi_pkg::DMI_ACCESS &&
                (dmi_op == dbg_dmi_pkg::READ || dmi_op == dbg_dmi_pkg::WRITE)) begin
               // Op dropped while the previous one is still out
               if (pending || busy) begin
                  busy <= 1'b1;
               end else begin
                  dmi_req.wr_en <= (dmi_op == dbg_dmi_pkg::WRITE);
                  dmi_req.addr  <= dr[`DMI_DR_W-1 -: `DMI_ABITS];
                  dmi_req.wdata <= dr[2 +: `DMI_DATA_W];
                  req_toggle    <= ~req_toggle;
               end
            end
         end
      end
   end

   // TDO launched on the falling edge
   always_ff @(negedge jtag_tck or negedge jtag_trst_n) begin
      if (!jtag_trst_n) begin
         jtag_tdo    <= 1'b0;
         jtag_tdo_en <= 1'b0;
      end else begin
         jtag_tdo_en <= (state == dbg_dmi_pkg::SHIFT_DR) || (state == dbg_dmi_pkg::SHIFT_IR);
         jtag_tdo    <= (state == dbg_dmi_pkg::SHIFT_IR) ? ir_shift[0] : dr[0];
      end
   end

   a_tms_reset: assert property (@(posedge jtag_tck) disable iff (!jtag_trst_n)
      jtag_tms [*5] |=> state == dbg_dmi_pkg::TEST_LOGIC_RESET);

   // Acknowledge only ever answers a launched request
   a_ack_pending: assert property (@(posedge jtag_tck) disable iff (!jtag_trst_n)
      $changed(ack_toggle) |-> $past(pending));

endmodule

`default_nettype wire

// ==== dbg_dmi_sync.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dbg_dmi_defines.svh"

module dbg_dmi_sync (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   jtag_tck,
   input  wire logic                   jtag_trst_n,
   input  wire logic                   req_toggle,
   input  wire dbg_dmi_pkg::dmi_req_t  dmi_req_in,
   input  wire logic [`DMI_DATA_W-1:0] rdata,
   output logic                        req_en,
   output dbg_dmi_pkg::dmi_req_t       req,
   output logic                        ack_toggle,
   output logic [`DMI_DATA_W-1:0]      rsp_data
);

   logic [`SYNC_STAGES-1:0] req_sync;
   logic                    req_seen;
   logic                    req_edge;
   logic                    rd_pend;
   logic                    ack_clk;
   logic [`SYNC_STAGES-1:0] ack_sync;

   // ******************************
   // Core clock side
   // ******************************

   assign req_edge = req_sync[`SYNC_STAGES-1] ^ req_seen;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_sync <= '0;
         req_seen <= 1'b0;
         req_en   <= 1'b0;
         rd_pend  <= 1'b0;
         ack_clk  <= 1'b0;
      end else begin
         req_sync <= {req_sync[`SYNC_STAGES-2:0], req_toggle};
         req_seen <= req_sync[`SYNC_STAGES-1];
         req_en   <= req_edge;
         rd_pend  <= req_en;
         // Answer goes back once the read data is in
         if (rd_pend) begin
            ack_clk <= ~ack_clk;
         end
      end
   end

   // Request held stable by the TAP while pending
   always_ff @(posedge clk) begin
      if (req_edge) begin
         req <= dmi_req_in;
      end
      if (rd_pend) begin
         rsp_data <= rdata;
      end
   end

   // ******************************
   // JTAG clock side
   // ******************************

   always_ff @(posedge jtag_tck or negedge jtag_trst_n) begin
      if (!jtag_trst_n) begin
         ack_sync <= '0;
      end else begin
         ack_sync <= {ack_sync[`SYNC_STAGES-2:0], ack_clk};
      end
   end

   assign ack_toggle = ack_sync[`SYNC_STAGES-1];

   a_req_single: assert property (@(posedge clk) disable iff (!rst_n)
      req_en |=> !req_en);

endmodule

`default_nettype wire

// ==== dbg_dmi_mux.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dbg_dmi_defines.svh"

module dbg_dmi_mux (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   req_en,
   input  wire dbg_dmi_pkg::dmi_req_t  req,
   input  wire logic                   dmi_uncore_enable,
   input  wire logic [`DMI_DATA_W-1:0] dmi_core_rdata,
   input  wire logic [`DMI_DATA_W-1:0] dmi_uncore_rdata,
   output logic                        dmi_core_en,
   output dbg_dmi_pkg::dmi_req_t       dmi_core_req,
   output logic                        dmi_uncore_en,
   output dbg_dmi_pkg::dmi_req_t       dmi_uncore_req,
   output logic [`DMI_DATA_W-1:0]      rdata
);

   logic in_window;
   logic to_uncore;
   logic uncore_sel;

   // Uncore only when enabled and the address hits its window
   assign in_window = (req.addr >= `UNCORE_ADDR_LO) && (req.addr <= `UNCORE_ADDR_HI);
   assign to_uncore = dmi_uncore_enable && in_window;

   assign dmi_core_en    = req_en && !to_uncore;
   assign dmi_uncore_en  = req_en && to_uncore;
   assign dmi_core_req   = req;
   assign dmi_uncore_req = req;

   // Remember the target for the read data one cycle later
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         uncore_sel <= 1'b0;
      end else if (req_en) begin
         uncore_sel <= to_uncore;
      end
   end

   assign rdata = uncore_sel ? dmi_uncore_rdata : dmi_core_rdata;

   // Unknown routing inputs would pulse both targets or neither
   a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
      req_en |-> !$isunknown({dmi_uncore_enable, req.addr}));

endmodule

`default_nettype wire

// ==== dbg_dmi_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dbg_dmi_defines.svh"

module dbg_dmi_top (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   jtag_tck,
   input  wire logic                   jtag_trst_n,
   input  wire logic                   jtag_tms,
   input  wire logic                   jtag_tdi,
   output logic                        jtag_tdo,
   output logic                        jtag_tdo_en,
   input  wire logic [31:1]            jtag_id,
   input  wire logic                   dmi_uncore_enable,
   output logic                        dmi_core_en,
   output dbg_dmi_pkg::dmi_req_t       dmi_core_req,
   input  wire logic [`DMI_DATA_W-1:0] dmi_core_rdata,
   output logic                        dmi_uncore_en,
   output dbg_dmi_pkg::dmi_req_t       dmi_uncore_req,
   input  wire logic [`DMI_DATA_W-1:0] dmi_uncore_rdata
);

   // JTAG clock domain
   dbg_dmi_pkg::dmi_req_t      tap_req;
   logic                       req_toggle;
   logic                       ack_toggle;
   logic [`DMI_DATA_W-1:0]     rsp_data;

   // Core clock domain
   logic                       sync_req_en;
   dbg_dmi_pkg::dmi_req_t      sync_req;
   logic [`DMI_DATA_W-1:0]     mux_rdata;

   dbg_jtag_tap u_tap (
      .jtag_tck    (jtag_tck),
      .jtag_trst_n (jtag_trst_n),
      .jtag_tms    (jtag_tms),
      .jtag_tdi    (jtag_tdi),
      .jtag_id     (jtag_id),
      .ack_toggle  (ack_toggle),
      .rsp_data    (rsp_data),
      .jtag_tdo    (jtag_tdo),
      .jtag_tdo_en (jtag_tdo_en),
      .dmi_req     (tap_req),
      .req_toggle  (req_toggle)
   );

   dbg_dmi_sync u_sync (
      .clk         (clk),
      .rst_n       (rst_n),
      .jtag_tck    (jtag_tck),
      .jtag_trst_n (jtag_trst_n),
      .req_toggle  (req_toggle),
      .dmi_req_in  (tap_req),
      .rdata       (mux_rdata),
      .req_en      (sync_req_en),
      .req         (sync_req),
      .ack_toggle  (ack_toggle),
      .rsp_data    (rsp_data)
   );

   dbg_dmi_mux u_mux (
      .clk               (clk),
      .rst_n             (rst_n),
      .req_en            (sync_req_en),
      .req               (sync_req),
      .dmi_uncore_enable (dmi_uncore_enable),
      .dmi_core_rdata    (dmi_core_rdata),
      .dmi_uncore_rdata  (dmi_uncore_rdata),
      .dmi_core_en       (dmi_core_en),
      .dmi_core_req      (dmi_core_req),
      .dmi_uncore_en     (dmi_uncore_en),
      .dmi_uncore_req    (dmi_uncore_req),
      .rdata             (mux_rdata)
   );

endmodule

`default_nettype wire

// ==== tb_dbg_dmi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_dmi_top;

   localparam logic [31:0] id_word   = 32'h10e31913;
   localparam int          max_tests = 32;

   logic                  clk;
   logic                  rst_n;
   logic                  jtag_tck;
   logic                  jtag_trst_n;
   logic                  jtag_tms;
   logic                  jtag_tdi;
   logic                  jtag_tdo;
   logic                  jtag_tdo_en;
   logic [31:1]           jtag_id;
   logic                  dmi_uncore_enable;
   logic                  dmi_core_en;
   dbg_dmi_pkg::dmi_req_t dmi_core_req;
   logic [31:0]           dmi_core_rdata;
   logic                  dmi_uncore_en;
   dbg_dmi_pkg::dmi_req_t dmi_uncore_req;
   logic [31:0]           dmi_uncore_rdata;

   // Test table loaded from the pattern file
   string       t_name  [max_tests];
   string       t_kind  [max_tests];
   logic [31:0] t_addr  [max_tests];
   logic [31:0] t_wdata [max_tests];
   logic [31:0] t_uen   [max_tests];
   logic [31:0] t_core  [max_tests];
   logic [31:0] t_unc   [max_tests];
   logic [31:0] t_exp   [max_tests];
   int          n_tests;
   bit          run_started;

   int                    core_cnt;
   int                    unc_cnt;
   dbg_dmi_pkg::dmi_req_t seen_req;
   int                    errors;
   int                    test_errs;
   int                    passed;
   int                    failed;
   string                 cur_name;

   dbg_dmi_top u_dut (
      .clk               (clk),
      .rst_n             (rst_n),
      .jtag_tck          (jtag_tck),
      .jtag_trst_n       (jtag_trst_n),
      .jtag_tms          (jtag_tms),
      .jtag_tdi          (jtag_tdi),
      .jtag_tdo          (jtag_tdo),
      .jtag_tdo_en       (jtag_tdo_en),
      .jtag_id           (jtag_id),
      .dmi_uncore_enable (dmi_uncore_enable),
      .dmi_core_en       (dmi_core_en),
      .dmi_core_req      (dmi_core_req),
      .dmi_core_rdata    (dmi_core_rdata),
      .dmi_uncore_en     (dmi_uncore_en),
      .dmi_uncore_req    (dmi_uncore_req),
      .dmi_uncore_rdata  (dmi_uncore_rdata)
   );

   // ******************************
   // Clocks and target models
   // ******************************

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Offset so tck edges never meet clk edges
   initial begin
      jtag_tck = 1'b0;
      #2;
      forever #16 jtag_tck = ~jtag_tck;
   end

   always @(posedge clk) begin
      if (dmi_core_en === 1'b1) begin
         core_cnt = core_cnt + 1;
         seen_req = dmi_core_req;
      end
      if (dmi_uncore_en === 1'b1) begin
         unc_cnt  = unc_cnt + 1;
         seen_req = dmi_uncore_req;
      end
   end

   initial begin
      wait (run_started);
      #((n_tests + 1) * 120 * 32);
      $display("Watchdog expired before all tests finished");
      $display("Finished with errors");
      $finish;
   end

   // ******************************
   // JTAG scan tasks
   // ******************************

   task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
      @(negedge jtag_tck);
      jtag_tms = tms;
      jtag_tdi = tdi;
      @(posedge jtag_tck);
      tdo = jtag_tdo;
   endtask

   task automatic idle_tck(input int n);
      logic b;
      repeat (n) tck_cycle(1'b0, 1'b0, b);
   endtask

   task automatic ir_scan(input logic [4:0] code);
      logic b;
      int   i;
      tck_cycle(1'b1, 1'b0, b);
      tck_cycle(1'b1, 1'b0, b);
      tck_cycle(1'b0, 1'b0, b);
      tck_cycle(1'b0, 1'b0, b);
      for (i = 0; i < 5; i++) begin
         tck_cycle(i == 4, code[i], b);
      end
      tck_cycle(1'b1, 1'b0, b);
      tck_cycle(1'b0, 1'b0, b);
   endtask

   // Select-DR, Capture-DR, n shift bits LSB first, then Update-DR into idle
   task automatic dr_scan(input int n, input logic [63:0] din, output logic [63:0] dout);
      logic b;
      logic en_all;
      int   i;
      dout   = '0;
      en_all = 1'b1;
      tck_cycle(1'b1, 1'b0, b);
      tck_cycle(1'b0, 1'b0, b);
      tck_cycle(1'b0, 1'b0, b);
      for (i = 0; i < n; i++) begin
         tck_cycle(i == n - 1, din[i], b);
         dout[i] = b;
         en_all  = en_all & jtag_tdo_en;
      end
      tck_cycle(1'b1, 1'b0, b);
      tck_cycle(1'b0, 1'b0, b);
      // TDO driven only while shifting
      compare_value("tdo_en in shift", 32'd1, en_all);
      compare_value("tdo_en in idle", 32'd0, jtag_tdo_en);
   endtask

   task automatic dmi_scan(input logic [6:0] addr, input logic [31:0] data,
                           input logic [1:0] op, output logic [1:0] st,
                           output logic [31:0] rd, output logic [6:0] ra);
      logic [63:0] dout;
      dr_scan(41, {23'd0, addr, data, op}, dout);
      st = dout[1:0];
      rd = dout[33:2];
      ra = dout[40:34];
   endtask

   task automatic set_targets(input logic uen, input logic [31:0] core_rd,
                              input logic [31:0] unc_rd);
      @(negedge clk);
      dmi_uncore_enable = uen;
      dmi_core_rdata    = core_rd;
      dmi_uncore_rdata  = unc_rd;
   endtask

   task automatic compare_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
      if (act !== exp) begin
         $display("Fail %s %s expected %h actual %h", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic wait_enable;
      int i;
      i = 0;
      while (core_cnt + unc_cnt == 0 && i < 80) begin
         @(posedge clk);
         i++;
      end
      if (core_cnt + unc_cnt == 0) begin
         $display("%s: no DMI enable pulse came within 80 clk cycles", cur_name);
         test_errs++;
      end
   endtask

   // ******************************
   // Test sequence
   // ******************************

   task automatic run_test(input int k);
      logic [63:0] dout;
      logic [1:0]  st;
      logic [31:0] rd;
      logic [6:0]  ra;
      cur_name  = t_name[k];
      test_errs = 0;
      set_targets(t_uen[k][0], t_core[k], t_unc[k]);
      case (t_kind[k])
         "idcode": begin
            // Five TMS ones land in Test-Logic-Reset with IDCODE selected
            repeat (5) tck_cycle(1'b1, 1'b0, st[0]);
            idle_tck(1);
            dr_scan(32, 64'd0, dout);
            compare_value("idcode", t_exp[k], dout[31:0]);
         end
         "dtmcs": begin
            ir_scan(dbg_dmi_pkg::DTMCS);
            dr_scan(32, t_wdata[k], dout);
            compare_value("dtmcs", t_exp[k], dout[31:0]);
         end
         "bypass": begin
            ir_scan(t_addr[k][4:0]);
            dr_scan(32, t_wdata[k], dout);
            compare_value("tdo stream", t_exp[k], dout[31:0]);
         end
         "write": begin
            ir_scan(dbg_dmi_pkg::DMI_ACCESS);
            core_cnt = 0;
            unc_cnt  = 0;
            dmi_scan(t_addr[k][6:0], t_wdata[k], dbg_dmi_pkg::WRITE, st, rd, ra);
            wait_enable();
            idle_tck(6);
            compare_value("core pulses", t_exp[k][0] ? 32'd0 : 32'd1, core_cnt);
            compare_value("uncore pulses", t_exp[k], unc_cnt);
            compare_value("addr", t_addr[k], seen_req.addr);
            compare_value("wdata", t_wdata[k], seen_req.wdata);
            compare_value("wr_en", 32'd1, seen_req.wr_en);
         end
         "read": begin
            ir_scan(dbg_dmi_pkg::DMI_ACCESS);
            core_cnt = 0;
            unc_cnt  = 0;
            dmi_scan(t_addr[k][6:0], 32'd0, dbg_dmi_pkg::READ, st, rd, ra);
            wait_enable();
            idle_tck(6);
            dmi_scan(7'd0, 32'd0, dbg_dmi_pkg::NOP, st, rd, ra);
            compare_value("status", 32'd0, st);
            compare_value("rdata", t_exp[k], rd);
            compare_value("addr", t_addr[k], ra);
         end
         "busy": begin
            // Second op lands while the first is still in flight
            ir_scan(dbg_dmi_pkg::DMI_ACCESS);
            dmi_scan(t_addr[k][6:0], t_wdata[k], dbg_dmi_pkg::WRITE, st, rd, ra);
            dmi_scan(t_addr[k][6:0], t_wdata[k], dbg_dmi_pkg::WRITE, st, rd, ra);
            dmi_scan(7'd0, 32'd0, dbg_dmi_pkg::NOP, st, rd, ra);
            compare_value("status", t_exp[k], st);
            idle_tck(6);
         end
         "dmireset": begin
            ir_scan(dbg_dmi_pkg::DTMCS);
            dr_scan(32, t_wdata[k], dout);
            ir_scan(dbg_dmi_pkg::DMI_ACCESS);
            dmi_scan(7'd0, 32'd0, dbg_dmi_pkg::NOP, st, rd, ra);
            compare_value("status", t_exp[k], st);
         end
         default: begin
            $display("%s: unknown test kind %s in pattern file", cur_name, t_kind[k]);
            test_errs++;
         end
      endcase
      if (test_errs == 0) begin
         passed++;
         $display("Pass %s", cur_name);
      end else begin
         failed++;
         $display("Test %s failed with %0d errors", cur_name, test_errs);
      end
      errors += test_errs;
   endtask

   initial begin
      int    fd;
      int    rc;
      int    k;
      string tok;
      string rest;
      rst_n             = 1'b0;
      jtag_trst_n       = 1'b0;
      jtag_tms          = 1'b1;
      jtag_tdi          = 1'b0;
      jtag_id           = id_word[31:1];
      dmi_uncore_enable = 1'b0;
      dmi_core_rdata    = '0;
      dmi_uncore_rdata  = '0;
      errors            = 0;
      passed            = 0;
      failed            = 0;
      n_tests           = 0;
      core_cnt          = 0;
      unc_cnt           = 0;
      run_started       = 1'b0;
      fd = $fopen("dbg_dmi_patterns.txt", "r");
      if (fd == 0) begin
         $display("Cannot open pattern file dbg_dmi_patterns.txt");
         errors++;
      end else begin
         while (n_tests < max_tests && $fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
               rc = $fgets(rest, fd);
            end else begin
               t_name[n_tests] = tok;
               rc = $fscanf(fd, "%s %h %h %h %h %h %h", t_kind[n_tests], t_addr[n_tests],
                            t_wdata[n_tests], t_uen[n_tests], t_core[n_tests],
                            t_unc[n_tests], t_exp[n_tests]);
               if (rc != 7) begin
                  $display("Pattern line for %s is incomplete", tok);
                  errors++;
               end
               n_tests++;
            end
         end
         $fclose(fd);
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n       = 1'b1;
      jtag_trst_n = 1'b1;
      run_started = 1'b1;
      idle_tck(1);
      for (k = 0; k < n_tests; k++) begin
         run_test(k);
      end
      $display("Tests %0d, passed %0d, failed %0d, errors %0d", n_tests, passed, failed, errors);
      if (errors == 0 && n_tests > 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dbg_dmi_patterns.txt ====
# name kind addr wdata uncore_en core_rdata uncore_rdata expected, all hex
# write expects 1 for the uncore target and 0 for core; bypass uses addr as the IR code
id_reset    idcode   00 00000000 0 00000000 00000000 10e31913
dtmcs_read  dtmcs    00 00000000 0 00000000 00000000 00001071
wr_core_low write    05 deadbeef 1 00000000 00000000 0
wr_win_lo   write    20 cafe0001 1 00000000 00000000 1
wr_win_dis  write    20 cafe0002 0 00000000 00000000 0
wr_win_hi   write    4f 12345678 1 00000000 00000000 1
wr_above    write    50 87654321 1 00000000 00000000 0
rd_core     read     10 00000000 1 11112222 33334444 11112222
rd_uncore   read     24 00000000 1 55556666 77778888 77778888
rd_win_dis  read     24 00000000 0 9999aaaa bbbbcccc 9999aaaa
bypass_1f   bypass   1f 8badf00d 0 00000000 00000000 175be01a
bypass_05   bypass   05 13572468 0 00000000 00000000 26ae48d0
busy_b2b    busy     30 0000abcd 1 00000000 00000000 3
dmi_reset   dmireset 00 00010000 0 00000000 00000000 0
rd_after    read     4f 00000000 1 0f0f0f0f f0f0f0f0 f0f0f0f0

// ==== flist.f ====
+incdir+.
dbg_dmi_pkg.sv
dbg_jtag_tap.sv
dbg_dmi_sync.sv
dbg_dmi_mux.sv
dbg_dmi_top.sv
tb_dbg_dmi_top.sv
